// ==== common/uart_cmd_config.svh ====
`ifndef UART_CMD_CONFIG_SVH
`define UART_CMD_CONFIG_SVH

// Clock cycles per UART bit
`define UART_BAUD_DIV 434

// Idle bit-times between command frame and data frame of a write
`define UART_GAP_BITS 16

// Start, eight data bits, parity, stop
`define UART_FRAME_BITS 11

`endif

// ==== common/uart_cmd_pkg.sv ====
`default_nettype none

package uart_cmd_pkg;

  // Host command word: [15] rw, [14:8] address, [7:0] write data
  typedef logic [15:0] cmd_t;

  // Payload of one UART frame
  typedef logic [7:0] byte_t;

  // Remote register address
  typedef logic [6:0] reg_addr_t;

  // Command sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEND_CMD,
    ST_GAP,
    ST_SEND_DATA,
    ST_WAIT_RESP
  } seq_state_t;

endpackage

`default_nettype wire

// ==== uart_link/uart_frame_tx.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "uart_cmd_config.svh"

module uart_frame_tx (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  tx_start,
  input  uart_cmd_pkg::byte_t  tx_byte,
  output logic                 tx,
  output logic                 tx_busy
);

  localparam int CNT_W = $clog2(`UART_BAUD_DIV);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`UART_BAUD_DIV - 1);
  localparam logic [3:0] LAST_BIT = 4'(`UART_FRAME_BITS - 1);

  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_idx;
  // Data bits, parity and stop still to go out, LSB first
  logic [9:0]       shreg;
  logic             bit_end;

  assign bit_end = (baud_cnt == FULL_BIT);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx       <= 1'b1;
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else if (!tx_busy)
    begin
      if (tx_start)
      begin
        // Start bit goes out right away
        tx       <= 1'b0;
        tx_busy  <= 1'b1;
        baud_cnt <= '0;
        bit_idx  <= '0;
      end
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (bit_idx == LAST_BIT)
      begin
        // Stop bit held for a full bit time, line stays high
        tx_busy <= 1'b0;
      end
      else
      begin
        tx      <= shreg[0];
        bit_idx <= bit_idx + 4'd1;
      end
    end
    else
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!tx_busy && tx_start)
    begin
      // Stop, even parity, data
      shreg <= {1'b1, ^tx_byte, tx_byte};
    end
    else if (tx_busy && bit_end && bit_idx != LAST_BIT)
    begin
      shreg <= {1'b1, shreg[9:1]};
    end
  end

endmodule

`default_nettype wire

// ==== uart_link/uart_frame_rx.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "uart_cmd_config.svh"

module uart_frame_rx (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  rx,
  output logic                 rx_done,
  output uart_cmd_pkg::byte_t  rx_byte,
  output logic                 rx_err
);

  localparam int CNT_W = $clog2(`UART_BAUD_DIV);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`UART_BAUD_DIV - 1);
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`UART_BAUD_DIV / 2 - 1);
  localparam logic [3:0] LAST_BIT = 4'(`UART_FRAME_BITS - 1);
  localparam logic [3:0] PAR_BIT  = 4'(`UART_FRAME_BITS - 2);

  logic                rx_meta;
  logic                rx_sync;
  logic                rx_last;
  logic                busy;
  logic [CNT_W-1:0]    baud_cnt;
  logic [3:0]          bit_idx;
  uart_cmd_pkg::byte_t shreg;
  logic                par_bit;
  logic                bit_mid;

  // Two-flop synchronizer plus one stage for edge detection
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
    end
  end

  // Start bit is checked after half a bit, the rest a full bit apart
  assign bit_mid = busy && (baud_cnt == ((bit_idx == 4'd0) ? HALF_BIT : FULL_BIT));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_done  <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (!busy)
      begin
        if (rx_last && !rx_sync)
        begin
          busy     <= 1'b1;
          baud_cnt <= '0;
          bit_idx  <= '0;
        end
      end
      else if (bit_mid)
      begin
        baud_cnt <= '0;
        if (bit_idx == 4'd0 && rx_sync)
        begin
          // Line went back high, not a real start bit
          busy <= 1'b0;
        end
        else if (bit_idx == LAST_BIT)
        begin
          busy    <= 1'b0;
          rx_done <= 1'b1;
        end
        else
        begin
          bit_idx <= bit_idx + 4'd1;
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (bit_mid)
    begin
      if (bit_idx != 4'd0 && bit_idx < PAR_BIT)
      begin
        shreg <= {rx_sync, shreg[7:1]};
      end
      if (bit_idx == PAR_BIT)
      begin
        par_bit <= rx_sync;
      end
      if (bit_idx == LAST_BIT)
      begin
        rx_byte <= shreg;
        // Odd parity over data and parity bit, or low stop bit
        rx_err  <= (^{shreg, par_bit}) | ~rx_sync;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_cmd_sequencer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "uart_cmd_config.svh"

module uart_cmd_sequencer (
  input  wire                  clk,
  input  wire                  rst_n,
  input  uart_cmd_pkg::cmd_t   cmd_in,
  input  wire                  cmd_vld,
  output logic                 cmd_rdy,
  output logic                 tx_start,
  output uart_cmd_pkg::byte_t  tx_byte,
  input  wire                  tx_busy,
  input  wire                  rx_done,
  input  uart_cmd_pkg::byte_t  rx_byte,
  input  wire                  rx_err,
  output uart_cmd_pkg::byte_t  read_data,
  output logic                 read_rdy,
  output logic                 read_err
);

  localparam int GAP_CYCLES = `UART_GAP_BITS * `UART_BAUD_DIV;
  localparam int GAP_W      = $clog2(GAP_CYCLES);
  localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(GAP_CYCLES - 1);

  uart_cmd_pkg::seq_state_t state;
  uart_cmd_pkg::cmd_t       cmd_q;
  uart_cmd_pkg::reg_addr_t  cmd_addr;
  logic [GAP_W-1:0]         gap_cnt;
  logic                     busy_q;
  logic                     tx_done;
  logic                     accept;

  assign cmd_rdy  = (state == uart_cmd_pkg::ST_IDLE);
  assign accept   = cmd_vld && cmd_rdy;
  assign cmd_addr = cmd_in[14:8];

  // Frame finished when tx_busy falls
  assign tx_done = busy_q && !tx_busy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= uart_cmd_pkg::ST_IDLE;
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      busy_q   <= 1'b0;
      gap_cnt  <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      busy_q   <= tx_busy;
      case (state)
        uart_cmd_pkg::ST_IDLE:
        begin
          if (accept)
          begin
            tx_start <= 1'b1;
            state    <= uart_cmd_pkg::ST_SEND_CMD;
          end
        end
        uart_cmd_pkg::ST_SEND_CMD:
        begin
          if (tx_done)
          begin
            gap_cnt <= '0;
            if (cmd_q[15])
              state <= uart_cmd_pkg::ST_GAP;
            else
              state <= uart_cmd_pkg::ST_WAIT_RESP;
          end
        end
        uart_cmd_pkg::ST_GAP:
        begin
          if (gap_cnt == GAP_LAST)
          begin
            tx_start <= 1'b1;
            state    <= uart_cmd_pkg::ST_SEND_DATA;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        uart_cmd_pkg::ST_SEND_DATA:
        begin
          if (tx_done)
            state <= uart_cmd_pkg::ST_IDLE;
        end
        uart_cmd_pkg::ST_WAIT_RESP:
        begin
          // Leave one cycle after the result pulse
          if (read_rdy)
            state <= uart_cmd_pkg::ST_IDLE;
          else if (rx_done)
            read_rdy <= 1'b1;
        end
        default:
        begin
          state <= uart_cmd_pkg::ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q   <= cmd_in;
      tx_byte <= {cmd_in[15], cmd_addr};
    end
    else if (state == uart_cmd_pkg::ST_GAP && gap_cnt == GAP_LAST)
    begin
      tx_byte <= cmd_q[7:0];
    end
    if (state == uart_cmd_pkg::ST_WAIT_RESP && rx_done && !read_rdy)
    begin
      read_data <= rx_byte;
      read_err  <= rx_err;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_cmd_bridge.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_cmd_bridge (
  input  wire                  clk,
  input  wire                  rst_n,
  input  uart_cmd_pkg::cmd_t   cmd_in,
  input  wire                  cmd_vld,
  output logic                 cmd_rdy,
  input  wire                  rx,
  output logic                 tx,
  output uart_cmd_pkg::byte_t  read_data,
  output logic                 read_rdy,
  output logic                 read_err
);

  logic                tx_start;
  uart_cmd_pkg::byte_t tx_byte;
  logic                tx_busy;
  logic                rx_done;
  uart_cmd_pkg::byte_t rx_byte;
  logic                rx_err;

  uart_cmd_sequencer uart_cmd_sequencer_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_busy   (tx_busy),
    .rx_done   (rx_done),
    .rx_byte   (rx_byte),
    .rx_err    (rx_err),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_frame_tx uart_frame_tx_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  // Runs all the time, stray frames are dropped by the sequencer
  uart_frame_rx uart_frame_rx_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_done (rx_done),
    .rx_byte (rx_byte),
    .rx_err  (rx_err)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release a little after the edge so no flop sees it on the edge itself
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/uart_remote_model.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "uart_cmd_config.svh"

module uart_remote_model (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  tx,
  output logic                 rx,
  input  uart_cmd_pkg::byte_t  resp_byte,
  input  wire                  bad_parity,
  output logic                 frame_seen,
  output uart_cmd_pkg::byte_t  frame_byte,
  output logic                 frame_ok,
  output logic [63:0]          frame_time
);

  localparam int B = `UART_BAUD_DIV;

  uart_cmd_pkg::byte_t data;
  logic                par;
  logic                data_next;
  logic [63:0]         t_start;
  int                  i;

  task automatic send_frame(input uart_cmd_pkg::byte_t b, input logic flip_par);
    logic [10:0] bits;
    int          k;
    begin
      // Stop, parity, data, start
      bits = {1'b1, (^b) ^ flip_par, b, 1'b0};
      for (k = 0; k < `UART_FRAME_BITS - 1; k++)
      begin
        rx = bits[k];
        repeat (B) @(negedge clk);
      end
      // Stop bit stays on as the idle level while tx is watched again
      rx = bits[`UART_FRAME_BITS - 1];
    end
  endtask

  // Everything runs on the falling edge away from the DUT's sampling edge
  initial
  begin
    rx         = 1'b1;
    frame_seen = 1'b0;
    frame_byte = '0;
    frame_ok   = 1'b0;
    frame_time = '0;
    data_next  = 1'b0;
    forever
    begin
      @(negedge clk);
      frame_seen = 1'b0;
      if (rst_n && !tx)
      begin
        t_start = $time;
        repeat (B / 2) @(negedge clk);
        if (!tx)
        begin
          for (i = 0; i < 8; i++)
          begin
            repeat (B) @(negedge clk);
            data[i] = tx;
          end
          repeat (B) @(negedge clk);
          par = tx;
          repeat (B) @(negedge clk);
          frame_byte = data;
          frame_ok   = ~(^{data, par}) & tx;
          frame_time = t_start;
          frame_seen = 1'b1;
          if (data_next)
            data_next = 1'b0;
          else if (data[7])
            data_next = 1'b1;
          else
          begin
            // Read command gets its answer after 3 bit-times
            @(negedge clk);
            frame_seen = 1'b0;
            repeat (3 * B) @(negedge clk);
            send_frame(resp_byte, bad_parity);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/uart_cmd_bridge_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "uart_cmd_config.svh"

module uart_cmd_bridge_tb;

  localparam int PERIOD    = 100;
  localparam int B         = `UART_BAUD_DIV;
  localparam int ROW_LIMIT = (2 * `UART_FRAME_BITS + `UART_GAP_BITS + 8) * B;
  localparam int ROWS      = 8;

  logic                clk;
  logic                rst_n;
  uart_cmd_pkg::cmd_t  cmd_in;
  logic                cmd_vld;
  logic                cmd_rdy;
  logic                rx;
  logic                tx;
  uart_cmd_pkg::byte_t read_data;
  logic                read_rdy;
  logic                read_err;
  uart_cmd_pkg::byte_t resp_byte;
  logic                bad_parity;
  logic                frame_seen;
  uart_cmd_pkg::byte_t frame_byte;
  logic                frame_ok;
  logic [63:0]         frame_time;

  logic                    tbl_rw   [ROWS];
  uart_cmd_pkg::reg_addr_t tbl_addr [ROWS];
  uart_cmd_pkg::byte_t     tbl_data [ROWS];
  uart_cmd_pkg::byte_t     tbl_resp [ROWS];
  logic                    tbl_bad  [ROWS];

  // Frames decoded on tx by the remote model
  uart_cmd_pkg::byte_t seen_byte [$];
  logic                seen_ok   [$];
  logic [63:0]         seen_time [$];

  int   err_cnt;
  int   pass_cnt;
  int   fail_cnt;
  int   exp_frames;
  int   errs0;
  int   r;
  logic timed_out;

  tb_clock_gen #(
    .PERIOD_NS    (PERIOD),
    .RESET_CYCLES (5)
  ) tb_clock_gen_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_cmd_bridge uart_cmd_bridge_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_remote_model uart_remote_model_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx         (tx),
    .rx         (rx),
    .resp_byte  (resp_byte),
    .bad_parity (bad_parity),
    .frame_seen (frame_seen),
    .frame_byte (frame_byte),
    .frame_ok   (frame_ok),
    .frame_time (frame_time)
  );

  always @(posedge clk)
  begin
    if (frame_seen)
    begin
      seen_byte.push_back(frame_byte);
      seen_ok.push_back(frame_ok);
      seen_time.push_back(frame_time);
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string sig, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, sig, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before && !timed_out)
    begin
      pass_cnt++;
      $display("%s: ok", name);
    end
    else
    begin
      fail_cnt++;
      $display("%s: mismatch", name);
    end
  endtask

  task automatic set_row(input int i, input logic rw, input logic [6:0] addr,
                         input logic [7:0] data, input logic [7:0] resp, input logic bad);
    tbl_rw[i]   = rw;
    tbl_addr[i] = addr;
    tbl_data[i] = data;
    tbl_resp[i] = resp;
    tbl_bad[i]  = bad;
  endtask

  task automatic load_table();
    int seed;
    begin
      seed = $urandom(68);
      set_row(0, 1'b1, 7'h12, 8'hA5, 8'h00, 1'b0);
      set_row(1, 1'b0, 7'h12, 8'h00, 8'h3C, 1'b0);
      set_row(2, 1'b1, 7'h7F, 8'($urandom), 8'h00, 1'b0);
      set_row(3, 1'b0, 7'h05, 8'h00, 8'($urandom), 1'b0);
      set_row(4, 1'b0, 7'h40, 8'h00, 8'h81, 1'b1);
      set_row(5, 1'b1, 7'h00, 8'h00, 8'h00, 1'b0);
      set_row(6, 1'b0, 7'h33, 8'h00, 8'($urandom), 1'b1);
      set_row(7, 1'b0, 7'h01, 8'h00, 8'hFF, 1'b0);
    end
  endtask

  task automatic run_row(input int i);
    int                  base;
    int                  cycles;
    int                  pulses;
    int                  n_exp;
    logic                done;
    uart_cmd_pkg::byte_t got_data;
    logic                got_err;
    logic [63:0]         gap;
    begin
      base       = seen_byte.size();
      n_exp      = tbl_rw[i] ? 2 : 1;
      resp_byte  = tbl_resp[i];
      bad_parity = tbl_bad[i];
      cmd_in     = {tbl_rw[i], tbl_addr[i], tbl_data[i]};
      cmd_vld    = 1'b1;
      step();
      check_value("cmd_rdy", cmd_rdy, 1'b0);
      // Even rows keep cmd_vld high for the whole transaction
      if (i % 2)
        cmd_vld = 1'b0;
      cycles = 0;
      pulses = 0;
      done   = 1'b0;
      while (!done && cycles < ROW_LIMIT)
      begin
        step();
        cycles++;
        if (read_rdy)
        begin
          pulses++;
          got_data = read_data;
          got_err  = read_err;
        end
        if (cmd_rdy)
        begin
          done    = 1'b1;
          cmd_vld = 1'b0;
        end
      end
      if (!done)
      begin
        $display("Timeout: row %0d did not return cmd_rdy within %0d cycles", i, ROW_LIMIT);
        timed_out = 1'b1;
        cmd_vld   = 1'b0;
      end
      else
      begin
        exp_frames += n_exp;
        check_value("frame_count", seen_byte.size() - base, n_exp);
        if (seen_byte.size() == base + n_exp)
        begin
          check_value("tx_cmd_byte", seen_byte[base], {tbl_rw[i], tbl_addr[i]});
          check_value("tx_parity_stop_ok", seen_ok[base], 1'b1);
          if (tbl_rw[i])
          begin
            check_value("tx_data_byte", seen_byte[base + 1], tbl_data[i]);
            check_value("tx_parity_stop_ok", seen_ok[base + 1], 1'b1);
            gap = seen_time[base + 1] - seen_time[base] - `UART_FRAME_BITS * B * PERIOD;
            check_value("tx_idle_gap_ok", gap >= `UART_GAP_BITS * B * PERIOD, 1'b1);
            // cmd_rdy may only come back once the data frame's stop bit is over
            check_value("cmd_rdy_after_frame_ok",
                        $time + PERIOD / 2 - seen_time[base + 1]
                          >= `UART_FRAME_BITS * B * PERIOD, 1'b1);
          end
        end
        check_value("read_rdy_pulses", pulses, tbl_rw[i] ? 0 : 1);
        if (!tbl_rw[i] && pulses == 1)
        begin
          check_value("read_data", got_data, tbl_resp[i]);
          check_value("read_err", got_err, tbl_bad[i]);
        end
      end
    end
  endtask

  initial
  begin
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    resp_byte  = '0;
    bad_parity = 1'b0;
    err_cnt    = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    exp_frames = 0;
    timed_out  = 1'b0;
    load_table();

    r = 0;
    while (!rst_n && r < 20)
    begin
      step();
      r++;
    end
    if (!rst_n)
    begin
      $display("Timeout: reset was never released");
      timed_out = 1'b1;
    end
    else
    begin
      errs0 = err_cnt;
      step();
      check_value("tx", tx, 1'b1);
      check_value("cmd_rdy", cmd_rdy, 1'b1);
      check_value("read_rdy", read_rdy, 1'b0);
      report_test("After reset", errs0);
    end

    for (r = 0; r < ROWS && !timed_out; r++)
    begin
      errs0 = err_cnt;
      run_row(r);
      report_test($sformatf("Row %0d %s addr 0x%02h", r, tbl_rw[r] ? "write" : "read",
                            tbl_addr[r]), errs0);
    end

    if (!timed_out)
    begin
      // No stray frames after the last command
      errs0 = err_cnt;
      for (int k = 0; k < 2 * `UART_FRAME_BITS * B; k++)
        step();
      check_value("frame_count_total", seen_byte.size(), exp_frames);
      report_test("Idle line", errs0);
    end

    $display("Tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && !timed_out)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== uart_cmd_bridge.f ====
+incdir+common
common/uart_cmd_pkg.sv
uart_link/uart_frame_tx.sv
uart_link/uart_frame_rx.sv
rtl/uart_cmd_sequencer.sv
rtl/uart_cmd_bridge.sv
tests/tb_clock_gen.sv
tests/uart_remote_model.sv
tests/uart_cmd_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: uart_cmd_bridge

export_include_dirs:
  - common

sources:
  - common/uart_cmd_pkg.sv
  - uart_link/uart_frame_tx.sv
  - uart_link/uart_frame_rx.sv
  - rtl/uart_cmd_sequencer.sv
  - rtl/uart_cmd_bridge.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/uart_remote_model.sv
      - tests/uart_cmd_bridge_tb.sv
